// File: design/lc_defines.svh
`ifndef LC_DEFINES_SVH
`define LC_DEFINES_SVH

// Bus word sizes
`define MBUS_ADDR_WIDTH 8
`define MBUS_DATA_WIDTH 32

// Function ID sits in the low address bits
`define LC_FUNC_WIDTH 4

// Upper reply address bits, function ID fills the rest
`define LC_REPLY_PREFIX 4'hA

// Register file geometry
`define LC_RF_DATA_WIDTH 24
`define LC_RF_DEPTH 64
`define LC_RF_IDX_WIDTH 6

// Word memory geometry
`define LC_MEM_DATA_WIDTH 32
`define LC_MEM_ADDR_WIDTH 10
`define LC_MEM_DEPTH 1024

// Cycles from request to acknowledge
`define LC_MEM_LATENCY 2

// Burst length field in the second DMA word
`define LC_DMA_LEN_WIDTH 16

`endif

// File: design/mbus_pkg.sv
`include "lc_defines.svh"

package mbus_pkg;

	// Address and data words as seen on the bus side
	typedef logic [`MBUS_ADDR_WIDTH-1:0] mbus_addr_t;
	typedef logic [`MBUS_DATA_WIDTH-1:0] mbus_data_t;

	// Function IDs decoded from the low address bits
	typedef enum logic [`LC_FUNC_WIDTH-1:0]
	{
		FUNC_RF_READ   = 4'd0,
		FUNC_RF_WRITE  = 4'd1,
		FUNC_MEM_READ  = 4'd2,
		FUNC_MEM_WRITE = 4'd3,
		FUNC_DMA_READ  = 4'd4,
		FUNC_DMA_WRITE = 4'd5
	} lc_func_e;

endpackage

// File: design/lc_pkg.sv
`include "lc_defines.svh"

package lc_pkg;

	// Storage words
	typedef logic [`LC_RF_DATA_WIDTH-1:0]  rf_word_t;
	typedef logic [`LC_RF_IDX_WIDTH-1:0]   rf_idx_t;
	typedef logic [`LC_MEM_DATA_WIDTH-1:0] mem_word_t;
	typedef logic [`LC_MEM_ADDR_WIDTH-1:0] mem_addr_t;
	typedef logic [`LC_DMA_LEN_WIDTH-1:0]  dma_len_t;

	// Controller main states
	typedef enum logic [2:0]
	{
		IDLE,
		PROC,
		BUS_TX,
		WAIT_CPL,
		INT
	} lc_state_e;

	// Sub-steps inside PROC
	typedef enum logic [2:0]
	{
		STEP_ADDR,
		STEP_LEN,
		STEP_DATA,
		STEP_ISSUE,
		STEP_ACCESS
	} lc_step_e;

endpackage

// File: design/layer_ctrl.sv
`timescale 1ns/100ps
`include "lc_defines.svh"

module layer_ctrl
	import mbus_pkg::*, lc_pkg::*;
(
	input  logic                                     CLK,
	input  logic                                     MEM_ACK_RSTn,
	// Bus receive side
	input  mbus_addr_t                               RX_ADDR,
	input  mbus_data_t                               RX_DATA,
	input  logic                                     RX_PEND,
	input  logic                                     RX_REQ,
	input  logic                                     RX_FAIL,
	output logic                                     RX_ACK,
	// Bus transmit side
	output mbus_addr_t                               TX_ADDR,
	output mbus_data_t                               TX_DATA,
	output logic                                     TX_PEND,
	output logic                                     TX_REQ,
	input  logic                                     TX_ACK,
	input  logic                                     TX_SUCC,
	input  logic                                     TX_FAIL,
	output logic                                     TX_RESP_ACK,
	// Register file
	input  logic [`LC_RF_DATA_WIDTH*`LC_RF_DEPTH-1:0] RF_DIN,
	output rf_word_t                                 RF_DOUT,
	output logic [`LC_RF_DEPTH-1:0]                  RF_LOAD,
	// Word memory
	output logic                                     MEM_REQ_OUT,
	output logic                                     MEM_WRITE,
	output mem_addr_t                                MEM_AOUT,
	output mem_word_t                                MEM_DOUT,
	input  logic                                     MEM_ACK_IN,
	input  mem_word_t                                MEM_DIN,
	// Interrupt
	input  logic                                     INTERRUPT,
	output logic                                     CLR_INT
);

lc_state_e  state;
lc_step_e   step;
lc_func_e   func;
mbus_data_t rx_buf;
logic       rx_pend;
dma_len_t   dma_cnt;

rf_idx_t    rf_idx;
rf_word_t   rf_word;
dma_len_t   rx_len;
logic       rx_new;
logic       idx_ok;
logic       addr_ok;

// Index in the top data byte, value below it
assign rf_idx  = rx_buf[`LC_RF_DATA_WIDTH +: `LC_RF_IDX_WIDTH];
assign idx_ok  = rx_buf[`MBUS_DATA_WIDTH-1:`LC_RF_DATA_WIDTH] < `LC_RF_DEPTH;
assign rf_word = RF_DIN[rf_idx*`LC_RF_DATA_WIDTH +: `LC_RF_DATA_WIDTH];

assign addr_ok = rx_buf < `LC_MEM_DEPTH;
assign rx_len  = RX_DATA[`LC_DMA_LEN_WIDTH-1:0];

// New word on the receive side, guarded against double trigger
assign rx_new  = RX_REQ && !RX_ACK;

always_ff @(posedge CLK or negedge MEM_ACK_RSTn)
begin
	if (!MEM_ACK_RSTn)
	begin
		state       <= IDLE;
		step        <= STEP_ADDR;
		func        <= FUNC_RF_READ;
		rx_buf      <= '0;
		rx_pend     <= 1'b0;
		dma_cnt     <= '0;
		RX_ACK      <= 1'b0;
		TX_ADDR     <= '0;
		TX_DATA     <= '0;
		TX_PEND     <= 1'b0;
		TX_REQ      <= 1'b0;
		TX_RESP_ACK <= 1'b0;
		RF_DOUT     <= '0;
		RF_LOAD     <= '0;
		MEM_REQ_OUT <= 1'b0;
		MEM_WRITE   <= 1'b0;
		MEM_AOUT    <= '0;
		MEM_DOUT    <= '0;
		CLR_INT     <= 1'b0;
	end
	else
	begin
		RF_LOAD <= '0;

		// Four-phase release once the master has let go
		if (RX_ACK && !RX_REQ && !RX_FAIL)
			RX_ACK <= 1'b0;

		case (state)
			IDLE:
			begin
				step <= STEP_ADDR;
				if (INTERRUPT)
				begin
					CLR_INT <= 1'b1;
					state   <= INT;
				end
				else if (rx_new)
				begin
					RX_ACK  <= 1'b1;
					rx_buf  <= RX_DATA;
					rx_pend <= RX_PEND;
					func    <= lc_func_e'(RX_ADDR[`LC_FUNC_WIDTH-1:0]);
					state   <= PROC;
				end
				else if (RX_FAIL && !RX_ACK)
					RX_ACK <= 1'b1;
			end

			PROC:
			begin
				// A failed receive aborts whatever is going on
				if (RX_FAIL && !RX_ACK)
				begin
					RX_ACK      <= 1'b1;
					MEM_REQ_OUT <= 1'b0;
					state       <= IDLE;
				end
				else
				begin
					case (step)
						STEP_ADDR:
						begin
							case (func)
								FUNC_RF_READ:
								begin
									if (idx_ok)
									begin
										TX_ADDR <= {`LC_REPLY_PREFIX, func};
										TX_DATA <= {rx_buf[`MBUS_DATA_WIDTH-1:`LC_RF_DATA_WIDTH], rf_word};
										TX_PEND <= 1'b0;
										TX_REQ  <= 1'b1;
										state   <= BUS_TX;
									end
									else
										state <= IDLE;
								end
								FUNC_RF_WRITE:
								begin
									if (idx_ok)
									begin
										RF_DOUT         <= rx_buf[`LC_RF_DATA_WIDTH-1:0];
										RF_LOAD[rf_idx] <= 1'b1;
									end
									// Chained writes keep coming while pending
									if (idx_ok && rx_pend)
										step <= STEP_DATA;
									else
										state <= IDLE;
								end
								FUNC_MEM_READ:
								begin
									MEM_AOUT <= rx_buf[`LC_MEM_ADDR_WIDTH-1:0];
									dma_cnt  <= dma_len_t'(1);
									if (addr_ok)
										step <= STEP_ISSUE;
									else
										state <= IDLE;
								end
								FUNC_MEM_WRITE:
								begin
									MEM_AOUT <= rx_buf[`LC_MEM_ADDR_WIDTH-1:0];
									dma_cnt  <= dma_len_t'(1);
									if (addr_ok && rx_pend)
										step <= STEP_DATA;
									else
										state <= IDLE;
								end
								FUNC_DMA_READ, FUNC_DMA_WRITE:
								begin
									MEM_AOUT <= rx_buf[`LC_MEM_ADDR_WIDTH-1:0];
									if (addr_ok && rx_pend)
										step <= STEP_LEN;
									else
										state <= IDLE;
								end
								default:
									state <= IDLE;
							endcase
						end

						STEP_LEN:
						begin
							if (rx_new)
							begin
								RX_ACK  <= 1'b1;
								rx_pend <= RX_PEND;
								dma_cnt <= rx_len;
								// Zero length or a burst past the end is dropped
								if (rx_len == '0 || (MEM_AOUT + rx_len) > `LC_MEM_DEPTH)
									state <= IDLE;
								else if (func == FUNC_DMA_READ)
									step <= STEP_ISSUE;
								else if (RX_PEND)
									step <= STEP_DATA;
								else
									state <= IDLE;
							end
						end

						STEP_DATA:
						begin
							if (rx_new)
							begin
								RX_ACK  <= 1'b1;
								rx_pend <= RX_PEND;
								if (func == FUNC_RF_WRITE)
								begin
									rx_buf <= RX_DATA;
									step   <= STEP_ADDR;
								end
								else
								begin
									MEM_DOUT    <= RX_DATA;
									MEM_WRITE   <= 1'b1;
									MEM_REQ_OUT <= 1'b1;
									dma_cnt     <= dma_cnt - 1'b1;
									step        <= STEP_ACCESS;
								end
							end
						end

						STEP_ISSUE:
						begin
							MEM_WRITE   <= 1'b0;
							MEM_REQ_OUT <= 1'b1;
							dma_cnt     <= dma_cnt - 1'b1;
							step        <= STEP_ACCESS;
						end

						STEP_ACCESS:
						begin
							if (MEM_ACK_IN)
							begin
								MEM_REQ_OUT <= 1'b0;
								MEM_AOUT    <= MEM_AOUT + 1'b1;
								if (!MEM_WRITE)
								begin
									// Read word goes out, pending while more remain
									TX_ADDR <= {`LC_REPLY_PREFIX, func};
									TX_DATA <= MEM_DIN;
									TX_PEND <= (dma_cnt != '0);
									TX_REQ  <= 1'b1;
									step    <= STEP_ISSUE;
									state   <= BUS_TX;
								end
								else if (dma_cnt != '0 && rx_pend)
									step <= STEP_DATA;
								else
									state <= IDLE;
							end
						end

						default:
							state <= IDLE;
					endcase
				end
			end

			BUS_TX:
			begin
				// Hold the word until acknowledged, then wait for ACK low
				if (TX_REQ && TX_ACK)
					TX_REQ <= 1'b0;
				else if (!TX_REQ && !TX_ACK)
				begin
					if (TX_PEND)
						state <= PROC;
					else
						state <= WAIT_CPL;
				end
			end

			WAIT_CPL:
			begin
				// Success and failure are answered the same way
				if ((TX_SUCC || TX_FAIL) && !TX_RESP_ACK)
					TX_RESP_ACK <= 1'b1;
				else if (TX_RESP_ACK && !TX_SUCC && !TX_FAIL)
				begin
					TX_RESP_ACK <= 1'b0;
					state       <= IDLE;
				end
			end

			INT:
			begin
				if (!INTERRUPT)
				begin
					CLR_INT <= 1'b0;
					state   <= IDLE;
				end
			end

			default:
				state <= IDLE;
		endcase
	end
end

endmodule

// File: design/lc_reg_file.sv
`timescale 1ns/100ps
`include "lc_defines.svh"

module lc_reg_file
	import lc_pkg::*;
(
	input  logic                                     CLK,
	input  logic                                     MEM_ACK_RSTn,
	input  logic [`LC_RF_DEPTH-1:0]                  RF_LOAD,
	input  rf_word_t                                 RF_DOUT,
	output logic [`LC_RF_DATA_WIDTH*`LC_RF_DEPTH-1:0] RF_DIN
);

// One register per strobe bit, all shown side by side
for (genvar i = 0; i < `LC_RF_DEPTH; i++)
begin : g_reg
	rf_word_t q;

	always_ff @(posedge CLK or negedge MEM_ACK_RSTn)
	begin
		if (!MEM_ACK_RSTn)
			q <= '0;
		else if (RF_LOAD[i])
			q <= RF_DOUT;
	end

	// Register i lands in slice i of the flat bus
	assign RF_DIN[i*`LC_RF_DATA_WIDTH +: `LC_RF_DATA_WIDTH] = q;
end

endmodule

// File: design/lc_mem.sv
`timescale 1ns/100ps
`include "lc_defines.svh"

module lc_mem
	import lc_pkg::*;
(
	input  logic      CLK,
	input  logic      MEM_ACK_RSTn,
	input  logic      MEM_REQ_OUT,
	input  logic      MEM_WRITE,
	input  mem_addr_t MEM_AOUT,
	input  mem_word_t MEM_DOUT,
	output logic      MEM_ACK_IN,
	output mem_word_t MEM_DIN
);

localparam int CNT_W = $clog2(`LC_MEM_LATENCY + 1);

mem_word_t        mem [`LC_MEM_DEPTH];
logic [CNT_W-1:0] lat_cnt;
logic             served;
logic             ack_due;

// Last counting cycle of a request not yet answered
assign ack_due = MEM_REQ_OUT && !served && (lat_cnt == CNT_W'(`LC_MEM_LATENCY - 1));

always_ff @(posedge CLK or negedge MEM_ACK_RSTn)
begin
	if (!MEM_ACK_RSTn)
	begin
		lat_cnt    <= '0;
		served     <= 1'b0;
		MEM_ACK_IN <= 1'b0;
	end
	else
	begin
		MEM_ACK_IN <= ack_due;
		if (!MEM_REQ_OUT)
		begin
			lat_cnt <= '0;
			served  <= 1'b0;
		end
		else if (ack_due)
			served <= 1'b1;
		else if (!served)
			lat_cnt <= lat_cnt + 1'b1;
	end
end

always_ff @(posedge CLK)
begin
	// Read word ready together with the acknowledge
	if (ack_due && !MEM_WRITE)
		MEM_DIN <= mem[MEM_AOUT];
	// Write commits at the end of the acknowledge cycle
	if (MEM_ACK_IN && MEM_WRITE)
		mem[MEM_AOUT] <= MEM_DOUT;
end

endmodule

// File: design/lc_top.sv
`timescale 1ns/100ps
`include "lc_defines.svh"

module lc_top
	import mbus_pkg::*, lc_pkg::*;
(
	input  logic       CLK,
	input  logic       MEM_ACK_RSTn,
	// Bus receive side
	input  mbus_addr_t RX_ADDR,
	input  mbus_data_t RX_DATA,
	input  logic       RX_PEND,
	input  logic       RX_REQ,
	input  logic       RX_FAIL,
	output logic       RX_ACK,
	// Bus transmit side
	output mbus_addr_t TX_ADDR,
	output mbus_data_t TX_DATA,
	output logic       TX_PEND,
	output logic       TX_REQ,
	input  logic       TX_ACK,
	input  logic       TX_SUCC,
	input  logic       TX_FAIL,
	output logic       TX_RESP_ACK,
	// Interrupt
	input  logic       INTERRUPT,
	output logic       CLR_INT
);

// Controller to register file
logic [`LC_RF_DATA_WIDTH*`LC_RF_DEPTH-1:0] rf_din;
rf_word_t                                 rf_dout;
logic [`LC_RF_DEPTH-1:0]                  rf_load;

// Controller to memory
logic      mem_req;
logic      mem_write;
mem_addr_t mem_aout;
mem_word_t mem_dout;
logic      mem_ack;
mem_word_t mem_din;

layer_ctrl u_ctrl
(
	.CLK          (CLK),
	.MEM_ACK_RSTn (MEM_ACK_RSTn),
	.RX_ADDR      (RX_ADDR),
	.RX_DATA      (RX_DATA),
	.RX_PEND      (RX_PEND),
	.RX_REQ       (RX_REQ),
	.RX_FAIL      (RX_FAIL),
	.RX_ACK       (RX_ACK),
	.TX_ADDR      (TX_ADDR),
	.TX_DATA      (TX_DATA),
	.TX_PEND      (TX_PEND),
	.TX_REQ       (TX_REQ),
	.TX_ACK       (TX_ACK),
	.TX_SUCC      (TX_SUCC),
	.TX_FAIL      (TX_FAIL),
	.TX_RESP_ACK  (TX_RESP_ACK),
	.RF_DIN       (rf_din),
	.RF_DOUT      (rf_dout),
	.RF_LOAD      (rf_load),
	.MEM_REQ_OUT  (mem_req),
	.MEM_WRITE    (mem_write),
	.MEM_AOUT     (mem_aout),
	.MEM_DOUT     (mem_dout),
	.MEM_ACK_IN   (mem_ack),
	.MEM_DIN      (mem_din),
	.INTERRUPT    (INTERRUPT),
	.CLR_INT      (CLR_INT)
);

lc_reg_file u_rf
(
	.CLK          (CLK),
	.MEM_ACK_RSTn (MEM_ACK_RSTn),
	.RF_LOAD      (rf_load),
	.RF_DOUT      (rf_dout),
	.RF_DIN       (rf_din)
);

lc_mem u_mem
(
	.CLK          (CLK),
	.MEM_ACK_RSTn (MEM_ACK_RSTn),
	.MEM_REQ_OUT  (mem_req),
	.MEM_WRITE    (mem_write),
	.MEM_AOUT     (mem_aout),
	.MEM_DOUT     (mem_dout),
	.MEM_ACK_IN   (mem_ack),
	.MEM_DIN      (mem_din)
);

endmodule

// File: tests/tb_lc_top.sv
`timescale 1ns/100ps
`include "lc_defines.svh"

module tb_lc_top
	import mbus_pkg::*, lc_pkg::*;
();

// Cycle limit for the whole run
localparam int          TIMEOUT_CYCLES = 20000;
localparam int          SILENCE_CYCLES = 50;
localparam logic [31:0] SEED           = 32'h2c01df70;

logic       CLK;
logic       MEM_ACK_RSTn;
mbus_addr_t RX_ADDR;
mbus_data_t RX_DATA;
logic       RX_PEND;
logic       RX_REQ;
logic       RX_FAIL;
logic       RX_ACK;
mbus_addr_t TX_ADDR;
mbus_data_t TX_DATA;
logic       TX_PEND;
logic       TX_REQ;
logic       TX_ACK;
logic       TX_SUCC;
logic       TX_FAIL;
logic       TX_RESP_ACK;
logic       INTERRUPT;
logic       CLR_INT;

// Reference copies of register file and memory
rf_word_t   ref_rf [`LC_RF_DEPTH];
mem_word_t  ref_mem [`LC_MEM_DEPTH];

// Expected and observed reply words, in arrival order
mbus_addr_t exp_addr_q [$];
mbus_data_t exp_data_q [$];
logic       exp_pend_q [$];
mbus_addr_t act_addr_q [$];
mbus_data_t act_data_q [$];
logic       act_pend_q [$];

int         tx_count;
int         err_count;
int         check_count;
int         test_count;
int         test_fail_count;
int         cycles;
logic       tx_busy;
logic       resp_fail;

lc_top UUT
(
	.CLK          (CLK),
	.MEM_ACK_RSTn (MEM_ACK_RSTn),
	.RX_ADDR      (RX_ADDR),
	.RX_DATA      (RX_DATA),
	.RX_PEND      (RX_PEND),
	.RX_REQ       (RX_REQ),
	.RX_FAIL      (RX_FAIL),
	.RX_ACK       (RX_ACK),
	.TX_ADDR      (TX_ADDR),
	.TX_DATA      (TX_DATA),
	.TX_PEND      (TX_PEND),
	.TX_REQ       (TX_REQ),
	.TX_ACK       (TX_ACK),
	.TX_SUCC      (TX_SUCC),
	.TX_FAIL      (TX_FAIL),
	.TX_RESP_ACK  (TX_RESP_ACK),
	.INTERRUPT    (INTERRUPT),
	.CLR_INT      (CLR_INT)
);

initial
begin
	CLK = 1'b0;
	forever #5 CLK = ~CLK;
end

// Expected reply data from the reference arrays
function automatic mbus_data_t ref_reply_data(input logic [3:0] fid, input logic [31:0] key);
	case (fid)
		FUNC_RF_READ:
			return {key[7:0], ref_rf[key[`LC_RF_IDX_WIDTH-1:0]]};
		FUNC_MEM_READ, FUNC_DMA_READ:
			return ref_mem[key[`LC_MEM_ADDR_WIDTH-1:0]];
		default:
			return '0;
	endcase
endfunction

task automatic expect_reply(input logic [3:0] fid, input logic [31:0] key, input logic pend);
	exp_addr_q.push_back({`LC_REPLY_PREFIX, fid});
	exp_data_q.push_back(ref_reply_data(fid, key));
	exp_pend_q.push_back(pend);
endtask

task automatic report_mismatch(input string name, input logic [31:0] want, input logic [31:0] got);
	$display("ERROR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, want, got);
	err_count++;
endtask

// One four-phase receive word
task automatic send_word(input logic [3:0] fid, input logic [31:0] data, input logic pend);
	@(posedge CLK);
	RX_ADDR <= {4'h3, fid};
	RX_DATA <= data;
	RX_PEND <= pend;
	RX_REQ  <= 1'b1;
	do @(posedge CLK); while (!RX_ACK);
	RX_REQ <= 1'b0;
	do @(posedge CLK); while (RX_ACK);
endtask

task automatic wait_replies();
	do @(posedge CLK); while (exp_addr_q.size() != 0 || act_addr_q.size() != 0 || tx_busy);
endtask

task automatic expect_silence(input string what);
	int start;
	start = tx_count;
	repeat (SILENCE_CYCLES) @(posedge CLK);
	check_count++;
	assert (tx_count == start)
	else
	begin
		$display("A reply came back at %0t after %s", $time, what);
		err_count++;
	end
endtask

task automatic rf_read(input logic [5:0] idx);
	expect_reply(FUNC_RF_READ, {26'h0, idx}, 1'b0);
	send_word(FUNC_RF_READ, {2'b00, idx, 24'h0}, 1'b0);
	wait_replies();
endtask

task automatic report_test(input string name, input int start_errs);
	test_count++;
	if (err_count == start_errs)
		$display("Test %0d %s: ok", test_count, name);
	else
	begin
		test_fail_count++;
		$display("Test %0d %s: %0d errors", test_count, name, err_count - start_errs);
	end
endtask

task automatic test_rf_chain();
	int         start_errs;
	logic [5:0] idx [8];
	rf_word_t   val;
	start_errs = err_count;
	for (int i = 0; i < 8; i++)
	begin
		idx[i] = 6'($urandom_range(0, `LC_RF_DEPTH - 1));
		val    = rf_word_t'($urandom());
		ref_rf[idx[i]] = val;
		send_word(FUNC_RF_WRITE, {2'b00, idx[i], val}, i != 7);
	end
	for (int i = 0; i < 8; i++)
		rf_read(idx[i]);
	report_test("RF chained write and read back", start_errs);
endtask

task automatic test_mem_single();
	int        start_errs;
	mem_addr_t addr;
	mem_word_t word;
	start_errs = err_count;
	addr = mem_addr_t'($urandom());
	word = $urandom();
	ref_mem[addr] = word;
	send_word(FUNC_MEM_WRITE, 32'(addr), 1'b1);
	send_word(FUNC_MEM_WRITE, word, 1'b0);
	expect_reply(FUNC_MEM_READ, 32'(addr), 1'b0);
	send_word(FUNC_MEM_READ, 32'(addr), 1'b0);
	wait_replies();
	send_word(FUNC_MEM_READ, `LC_MEM_DEPTH + $urandom_range(0, 255), 1'b0);
	expect_silence("a memory read past the end");
	report_test("memory single write and read", start_errs);
endtask

task automatic test_dma();
	int          start_errs;
	int unsigned n;
	int unsigned base;
	mem_word_t   word;
	start_errs = err_count;
	n    = $urandom_range(4, 8);
	base = $urandom_range(0, `LC_MEM_DEPTH - n);
	send_word(FUNC_DMA_WRITE, base, 1'b1);
	send_word(FUNC_DMA_WRITE, n, 1'b1);
	for (int i = 0; i < n; i++)
	begin
		word = $urandom();
		ref_mem[base + i] = word;
		send_word(FUNC_DMA_WRITE, word, i != n - 1);
	end
	// Replies in address order, pending on all but the last
	for (int i = 0; i < n; i++)
		expect_reply(FUNC_DMA_READ, base + i, i != n - 1);
	send_word(FUNC_DMA_READ, base, 1'b1);
	send_word(FUNC_DMA_READ, n, 1'b0);
	wait_replies();
	send_word(FUNC_DMA_READ, base, 1'b1);
	send_word(FUNC_DMA_READ, 32'h0, 1'b0);
	expect_silence("a DMA read with zero length");
	report_test("DMA burst write and read", start_errs);
endtask

task automatic test_resp_fail();
	int start_errs;
	start_errs = err_count;
	resp_fail = 1'b1;
	rf_read(6'($urandom_range(0, `LC_RF_DEPTH - 1)));
	resp_fail = 1'b0;
	rf_read(6'($urandom_range(0, `LC_RF_DEPTH - 1)));
	report_test("reply completion with TX_FAIL", start_errs);
endtask

task automatic test_interrupt();
	int start_errs;
	start_errs = err_count;
	@(posedge CLK);
	INTERRUPT <= 1'b1;
	do @(posedge CLK); while (!CLR_INT);
	repeat (3) @(posedge CLK);
	check_count++;
	assert (CLR_INT)
	else
	begin
		$display("CLR_INT dropped at %0t while INTERRUPT was still high", $time);
		err_count++;
	end
	INTERRUPT <= 1'b0;
	do @(posedge CLK); while (CLR_INT);
	rf_read(6'($urandom_range(0, `LC_RF_DEPTH - 1)));
	report_test("interrupt clear", start_errs);
endtask

// Bus side of the transmit handshake, with random back-pressure
initial
begin
	logic        pend;
	int unsigned delay;
	forever
	begin
		@(posedge CLK);
		if (TX_REQ)
		begin
			tx_busy = 1'b1;
			tx_count++;
			act_addr_q.push_back(TX_ADDR);
			act_data_q.push_back(TX_DATA);
			act_pend_q.push_back(TX_PEND);
			pend  = TX_PEND;
			delay = $urandom_range(0, 3);
			repeat (delay) @(posedge CLK);
			TX_ACK <= 1'b1;
			do @(posedge CLK); while (TX_REQ);
			TX_ACK <= 1'b0;
			if (!pend)
			begin
				if (resp_fail)
					TX_FAIL <= 1'b1;
				else
					TX_SUCC <= 1'b1;
				do @(posedge CLK); while (!TX_RESP_ACK);
				TX_SUCC <= 1'b0;
				TX_FAIL <= 1'b0;
				do @(posedge CLK); while (TX_RESP_ACK);
			end
			tx_busy = 1'b0;
		end
	end
end

// Compare observed replies against the expected queue
initial
begin
	mbus_addr_t got_addr;
	mbus_data_t got_data;
	logic       got_pend;
	forever
	begin
		@(posedge CLK);
		while (act_addr_q.size() > 0)
		begin
			got_addr = act_addr_q.pop_front();
			got_data = act_data_q.pop_front();
			got_pend = act_pend_q.pop_front();
			check_count++;
			assert (exp_addr_q.size() != 0)
			else
			begin
				$display("Reply 0x%0h at %0t arrived with no request waiting", got_data, $time);
				err_count++;
			end
			if (exp_addr_q.size() != 0)
			begin
				check_count += 3;
				assert (got_addr == exp_addr_q[0])
				else report_mismatch("TX_ADDR", 32'(exp_addr_q[0]), 32'(got_addr));
				assert (got_data == exp_data_q[0])
				else report_mismatch("TX_DATA", exp_data_q[0], got_data);
				assert (got_pend == exp_pend_q[0])
				else report_mismatch("TX_PEND", 32'(exp_pend_q[0]), 32'(got_pend));
				void'(exp_addr_q.pop_front());
				void'(exp_data_q.pop_front());
				void'(exp_pend_q.pop_front());
			end
		end
	end
end

initial
begin
	cycles = 0;
	while (cycles < TIMEOUT_CYCLES)
	begin
		@(posedge CLK);
		cycles++;
	end
	$display("Run stopped after %0d cycles, a handshake never completed", cycles);
	$display("=== FAIL ===");
	$finish;
end

initial
begin
	void'($urandom(SEED));
	MEM_ACK_RSTn    = 1'b0;
	RX_ADDR         = '0;
	RX_DATA         = '0;
	RX_PEND         = 1'b0;
	RX_REQ          = 1'b0;
	RX_FAIL         = 1'b0;
	TX_ACK          = 1'b0;
	TX_SUCC         = 1'b0;
	TX_FAIL         = 1'b0;
	INTERRUPT       = 1'b0;
	tx_busy         = 1'b0;
	resp_fail       = 1'b0;
	tx_count        = 0;
	err_count       = 0;
	check_count     = 0;
	test_count      = 0;
	test_fail_count = 0;
	for (int i = 0; i < `LC_RF_DEPTH; i++)
		ref_rf[i] = '0;
	repeat (8) @(posedge CLK);
	MEM_ACK_RSTn <= 1'b1;
	repeat (2) @(posedge CLK);
	test_rf_chain();
	test_mem_single();
	test_dma();
	test_resp_fail();
	test_interrupt();
	$display("Tests %0d, failed %0d, checks %0d, errors %0d (seed 0x%0h)",
		test_count, test_fail_count, check_count, err_count, SEED);
	if (err_count == 0)
		$display("=== PASS ===");
	else
		$display("=== FAIL ===");
	$finish;
end

endmodule

// File: all.f
+incdir+design
design/mbus_pkg.sv
design/lc_pkg.sv
design/layer_ctrl.sv
design/lc_reg_file.sv
design/lc_mem.sv
design/lc_top.sv
tests/tb_lc_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_lc_top -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_lc_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
	exit 0
fi
exit 1
